// File: Bender.yml
package:
  name: exceptionUnit

sources:
  # Packages first
  - hw/excCausePkg.sv
  - hw/excVectorPkg.sv
  # Leaf blocks
  - hw/exceptionPriority.sv
  - hw/interruptSequencer.sv
  - hw/saveStallTimer.sv
  - hw/clearTokenPipe.sv
  # Top level
  - hw/exceptionUnit.sv
  # Testbench
  - target: test
    files:
      - verification/exceptionUnitTb.sv

// File: exceptionUnit.f
hw/excCausePkg.sv
hw/excVectorPkg.sv
hw/exceptionPriority.sv
hw/interruptSequencer.sv
hw/saveStallTimer.sv
hw/clearTokenPipe.sv
hw/exceptionUnit.sv
verification/exceptionUnitTb.sv

// File: hw/clearTokenPipe.sv
`timescale 1ns/1ps

module clearTokenPipe
  import excCausePkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      PipelineClearF,
  input  logic      ExceptionStallD,
  input  flushVec_t ExceptionFlush,
  output logic      PipelineClearD,
  output logic      PipelineClearM,
  output logic      tokenAlive
);

  // Token position, one bit per stage
  logic tokD;
  logic tokE;
  logic tokM;

  always_ff @(posedge clk) begin
    if (rst) begin
      tokD <= 1'b0;
      tokE <= 1'b0;
      tokM <= 1'b0;
    end else if (ExceptionStallD) begin
      // Frozen in place, a flush still kills it
      // Token at F is not taken while decode is stalled
      tokD <= tokD & ~ExceptionFlush.d;
      tokE <= tokE & ~ExceptionFlush.e;
      tokM <= tokM & ~ExceptionFlush.m;
    end else begin
      // Advance one stage
      // A flushed stage hands nothing on
      tokD <= PipelineClearF;
      tokE <= tokD & ~ExceptionFlush.d;
      tokM <= tokE & ~ExceptionFlush.e;
    end
  end

  assign PipelineClearD = tokD;
  assign PipelineClearM = tokM;

  // Token somewhere between F and M
  assign tokenAlive = PipelineClearF | tokD | tokE | tokM;

endmodule

// File: hw/excCausePkg.sv
package excCausePkg;

  // Flush strobes per pipeline stage
  // D sits in the MSB, W in the LSB
  typedef struct packed {
    logic d;
    logic e;
    logic m;
    logic w;
  } flushVec_t;

  // No flush
  localparam flushVec_t FlushNone = 4'b0000;

  // Data abort caught in M, whole pipe goes
  localparam flushVec_t FlushDataAbort = 4'b1111;

  // Causes caught in E
  // W keeps the older instruction retiring
  localparam flushVec_t FlushSync = 4'b1110;

  // Interrupt assert with the clear token in M
  // Only D and M hold anything worth killing
  localparam flushVec_t FlushInterrupt = 4'b1010;

  // Interrupt the clear token is draining for
  typedef enum logic {
    KindFiq,
    KindIrq
  } intKind_t;

  // Interrupt sequencer states
  typedef enum logic [1:0] {
    Idle,
    Insert,
    Drain
  } seqState_t;

endpackage

// File: hw/excVectorPkg.sv
package excVectorPkg;

  // One-hot PC vector
  // MSB to LSB: FIQ, IRQ, abort 2nd cycle, prefetch, SWI, undef, reset
  typedef logic [6:0] pcVector_t;

  // Bit positions in pcVector_t
  localparam int VecFiq        = 6;
  localparam int VecIrq        = 5;
  localparam int VecDataAbort2 = 4;
  localparam int VecPrefetch   = 3;
  localparam int VecSwi        = 2;
  localparam int VecUndef      = 1;
  localparam int VecReset      = 0;

  // Decode stall while mov r14, pc goes in
  // Two cycles covers the inserted mov and its issue slot
  localparam int SaveCyclesDefault = 2;

endpackage

// File: hw/exceptionPriority.sv
`timescale 1ns/1ps

module exceptionPriority
  import excCausePkg::*, excVectorPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      DataAbort,
  input  logic      PrefetchAbortE,
  input  logic      UndefinedInstrE,
  input  logic      SWIE,
  input  logic      FIQAssert,
  input  logic      IRQAssert,
  output flushVec_t ExceptionFlush,
  output pcVector_t PCVectorAddress,
  output logic      ExceptionSavePC
);

  // Marks the cycle after a taken data abort
  logic dataAbort2;
  // Data abort that wins this cycle
  logic dataAbortTaken;
  // E-stage causes grouped, they share a flush pattern
  logic syncE;

  // A held abort level does not retrigger in its own 2nd cycle
  assign dataAbortTaken = DataAbort & ~dataAbort2;
  assign syncE          = PrefetchAbortE | UndefinedInstrE | SWIE;

  // Second-cycle marker
  always_ff @(posedge clk) begin
    if (rst) begin
      dataAbort2 <= 1'b0;
    end else begin
      dataAbort2 <= dataAbortTaken;
    end
  end

  // Flush strobes by fixed priority
  always_comb begin
    if (DataAbort) begin
      ExceptionFlush = FlushDataAbort;
    end else if (syncE) begin
      ExceptionFlush = FlushSync;
    end else if (FIQAssert || IRQAssert) begin
      ExceptionFlush = FlushInterrupt;
    end else begin
      ExceptionFlush = FlushNone;
    end
  end

  // One-hot vector of the winning cause
  always_comb begin
    PCVectorAddress = '0;
    // Reset vector rides on top of everything
    PCVectorAddress[VecReset] = rst;
    if (dataAbort2) begin
      // mov being inserted, nothing else goes out
      PCVectorAddress[VecDataAbort2] = 1'b1;
    end else if (DataAbort) begin
      // Abort vector follows next cycle
      PCVectorAddress[VecDataAbort2] = 1'b0;
    end else if (PrefetchAbortE) begin
      PCVectorAddress[VecPrefetch] = 1'b1;
    end else if (UndefinedInstrE) begin
      PCVectorAddress[VecUndef] = 1'b1;
    end else if (SWIE) begin
      PCVectorAddress[VecSwi] = 1'b1;
    end else if (FIQAssert) begin
      PCVectorAddress[VecFiq] = 1'b1;
    end else if (IRQAssert) begin
      PCVectorAddress[VecIrq] = 1'b1;
    end
  end

  // Any vector bit means the PC must be saved
  assign ExceptionSavePC = |PCVectorAddress;

endmodule

// File: hw/exceptionUnit.sv
`timescale 1ns/1ps

module exceptionUnit
  import excCausePkg::*, excVectorPkg::*;
#(
  parameter int SaveCycles = SaveCyclesDefault
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      DataAbort,
  input  logic      PrefetchAbortE,
  input  logic      UndefinedInstrE,
  input  logic      SWIE,
  input  logic      FIQ,
  input  logic      IRQ,
  input  logic      FIQEnabled,
  input  logic      IRQEnabled,
  output flushVec_t ExceptionFlush,
  output pcVector_t PCVectorAddress,
  output logic      ExceptionSavePC,
  output logic      ExceptionStallD,
  output logic      PipelineClearF,
  output logic      PipelineClearD,
  output logic      PipelineClearM,
  output logic      FIQAssert,
  output logic      IRQAssert
);

  // Any synchronous cause this cycle
  logic syncException;
  // Token still in flight
  logic tokenAlive;

  assign syncException = DataAbort | PrefetchAbortE | UndefinedInstrE | SWIE;

  exceptionPriority exceptionPriority_i (
    .clk             (clk),
    .rst             (rst),
    .DataAbort       (DataAbort),
    .PrefetchAbortE  (PrefetchAbortE),
    .UndefinedInstrE (UndefinedInstrE),
    .SWIE            (SWIE),
    .FIQAssert       (FIQAssert),
    .IRQAssert       (IRQAssert),
    .ExceptionFlush  (ExceptionFlush),
    .PCVectorAddress (PCVectorAddress),
    .ExceptionSavePC (ExceptionSavePC)
  );

  // Stall doubles as the sequencer's busy
  interruptSequencer interruptSequencer_i (
    .clk            (clk),
    .rst            (rst),
    .FIQ            (FIQ),
    .IRQ            (IRQ),
    .FIQEnabled     (FIQEnabled),
    .IRQEnabled     (IRQEnabled),
    .timerBusy      (ExceptionStallD),
    .syncException  (syncException),
    .tokenAlive     (tokenAlive),
    .PipelineClearM (PipelineClearM),
    .PipelineClearF (PipelineClearF),
    .FIQAssert      (FIQAssert),
    .IRQAssert      (IRQAssert)
  );

  saveStallTimer #(
    .SaveCycles (SaveCycles)
  ) saveStallTimer_i (
    .clk             (clk),
    .rst             (rst),
    .ExceptionSavePC (ExceptionSavePC),
    .ExceptionStallD (ExceptionStallD)
  );

  clearTokenPipe clearTokenPipe_i (
    .clk             (clk),
    .rst             (rst),
    .PipelineClearF  (PipelineClearF),
    .ExceptionStallD (ExceptionStallD),
    .ExceptionFlush  (ExceptionFlush),
    .PipelineClearD  (PipelineClearD),
    .PipelineClearM  (PipelineClearM),
    .tokenAlive      (tokenAlive)
  );

endmodule

// File: hw/interruptSequencer.sv
`timescale 1ns/1ps

module interruptSequencer
  import excCausePkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic FIQ,
  input  logic IRQ,
  input  logic FIQEnabled,
  input  logic IRQEnabled,
  input  logic timerBusy,
  input  logic syncException,
  input  logic tokenAlive,
  input  logic PipelineClearM,
  output logic PipelineClearF,
  output logic FIQAssert,
  output logic IRQAssert
);

  seqState_t state;
  seqState_t stateNext;
  // Interrupt recorded at the Idle decision
  intKind_t  kind;
  intKind_t  kindNext;
  // Masked requests
  logic      fiqReq;
  logic      irqReq;

  assign fiqReq = FIQ & FIQEnabled;
  assign irqReq = IRQ & IRQEnabled;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= Idle;
      kind  <= KindFiq;
    end else begin
      state <= stateNext;
      kind  <= kindNext;
    end
  end

  always_comb begin
    stateNext      = state;
    kindNext       = kind;
    PipelineClearF = 1'b0;
    FIQAssert      = 1'b0;
    IRQAssert      = 1'b0;
    case (state)
      Idle: begin
        // Wait out any save sequence first
        if (!timerBusy && (fiqReq || irqReq)) begin
          // FIQ wins a tie
          kindNext  = fiqReq ? KindFiq : KindIrq;
          stateNext = Insert;
        end
      end
      Insert: begin
        // Token enters at F for one cycle
        PipelineClearF = 1'b1;
        stateNext      = Drain;
      end
      Drain: begin
        if (PipelineClearM && !syncException) begin
          // Older instructions all retired, raise it now
          FIQAssert = (kind == KindFiq);
          IRQAssert = (kind == KindIrq);
          stateNext = Idle;
        end else if (PipelineClearM || !tokenAlive) begin
          // Pre-empted in M or flushed on the way, try again
          stateNext = Insert;
        end
      end
      default: begin
        stateNext = Idle;
      end
    endcase
  end

endmodule

// File: hw/saveStallTimer.sv
`timescale 1ns/1ps

module saveStallTimer
  import excVectorPkg::*;
#(
  parameter int SaveCycles = SaveCyclesDefault
) (
  input  logic clk,
  input  logic rst,
  input  logic ExceptionSavePC,
  output logic ExceptionStallD
);

  // Wide enough to hold SaveCycles itself
  localparam int CountW = $clog2(SaveCycles + 1);

  // Remaining stall cycles
  logic [CountW-1:0] count;

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (ExceptionSavePC) begin
      // New exception restarts the sequence
      count <= CountW'(SaveCycles);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // Decode held while mov r14, pc is issued
  assign ExceptionStallD = (count != '0);

endmodule

// File: verification/exceptionUnitTb.sv
`timescale 1ns/1ps

module exceptionUnitTb
  import excCausePkg::*, excVectorPkg::*;
();

  localparam int ClkPeriod   = 20;
  localparam int HalfPeriod  = ClkPeriod / 2;
  localparam int ResetCycles = 10;
  localparam int RandRows    = 200;
  localparam int MaxRows     = 64;
  localparam int SaveCycles  = 2;

  // One cycle of the trace
  // in  = {DataAbort, PrefetchAbortE, UndefinedInstrE, SWIE, FIQ, IRQ, FIQEnabled, IRQEnabled}
  // ctl = {SavePC, StallD, ClearF, ClearD, ClearM, FIQAssert, IRQAssert}
  typedef struct packed {
    logic [7:0] in;
    flushVec_t  flush;
    pcVector_t  vec;
    logic [6:0] ctl;
  } traceRow_t;

  logic clk;
  logic rst;
  logic DataAbort;
  logic PrefetchAbortE;
  logic UndefinedInstrE;
  logic SWIE;
  logic FIQ;
  logic IRQ;
  logic FIQEnabled;
  logic IRQEnabled;
  flushVec_t ExceptionFlush;
  pcVector_t PCVectorAddress;
  logic ExceptionSavePC;
  logic ExceptionStallD;
  logic PipelineClearF;
  logic PipelineClearD;
  logic PipelineClearM;
  logic FIQAssert;
  logic IRQAssert;

  traceRow_t  trace [MaxRows];
  int         traceLen;
  int         timeoutNs;
  int         i;
  string      where;
  // Random phase state and reference model
  integer     seed;
  logic [31:0] r;
  logic       da;
  logic       pa;
  logic       ud;
  logic       swi;
  logic       modelDa2;
  int         modelCount;
  flushVec_t  expFlush;
  pcVector_t  expVec;

  exceptionUnit #(
    .SaveCycles (SaveCycles)
  ) exceptionUnit_i (
    .clk             (clk),
    .rst             (rst),
    .DataAbort       (DataAbort),
    .PrefetchAbortE  (PrefetchAbortE),
    .UndefinedInstrE (UndefinedInstrE),
    .SWIE            (SWIE),
    .FIQ             (FIQ),
    .IRQ             (IRQ),
    .FIQEnabled      (FIQEnabled),
    .IRQEnabled      (IRQEnabled),
    .ExceptionFlush  (ExceptionFlush),
    .PCVectorAddress (PCVectorAddress),
    .ExceptionSavePC (ExceptionSavePC),
    .ExceptionStallD (ExceptionStallD),
    .PipelineClearF  (PipelineClearF),
    .PipelineClearD  (PipelineClearD),
    .PipelineClearM  (PipelineClearM),
    .FIQAssert       (FIQAssert),
    .IRQAssert       (IRQAssert)
  );

  initial clk = 1'b0;
  always #HalfPeriod clk = ~clk;

  task automatic checkFlush(input flushVec_t got, input flushVec_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED ExceptionFlush at %s: got 0x%h, expected 0x%h", where, got, exp);
      $display("** FAIL **");
      $fatal(1, "ExceptionFlush mismatch");
    end
  endtask

  task automatic checkVector(input pcVector_t got, input pcVector_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED PCVectorAddress at %s: got 0x%h, expected 0x%h", where, got, exp);
      $display("** FAIL **");
      $fatal(1, "PCVectorAddress mismatch");
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s at %s: got 0x%h, expected 0x%h", name, where, got, exp);
      $display("** FAIL **");
      $fatal(1, "single-bit output mismatch");
    end
  endtask

  task automatic compareRow(input flushVec_t flush, input pcVector_t vec, input logic [6:0] ctl);
    checkFlush(ExceptionFlush, flush);
    checkVector(PCVectorAddress, vec);
    checkBit("ExceptionSavePC", ExceptionSavePC, ctl[6]);
    checkBit("ExceptionStallD", ExceptionStallD, ctl[5]);
    checkBit("PipelineClearF", PipelineClearF, ctl[4]);
    checkBit("PipelineClearD", PipelineClearD, ctl[3]);
    checkBit("PipelineClearM", PipelineClearM, ctl[2]);
    checkBit("FIQAssert", FIQAssert, ctl[1]);
    checkBit("IRQAssert", IRQAssert, ctl[0]);
  endtask

  task automatic driveInputs(input logic [7:0] in);
    DataAbort       = in[7];
    PrefetchAbortE  = in[6];
    UndefinedInstrE = in[5];
    SWIE            = in[4];
    FIQ             = in[3];
    IRQ             = in[2];
    FIQEnabled      = in[1];
    IRQEnabled      = in[0];
  endtask

  task automatic addRow(input logic [7:0] in, input flushVec_t flush, input pcVector_t vec,
                        input logic [6:0] ctl);
    trace[traceLen] = {in, flush, vec, ctl};
    traceLen++;
  endtask

  // Expected flush strobes by cause priority
  function automatic flushVec_t flushFor(input logic a, input logic p, input logic u,
                                         input logic s);
    if (a) begin
      return 4'b1111;
    end else if (p || u || s) begin
      return 4'b1110;
    end
    return 4'b0000;
  endfunction

  // Expected vector bit of the winning cause
  // Abort second cycle blocks everything else
  function automatic pcVector_t vectorFor(input logic a2, input logic a, input logic p,
                                          input logic u, input logic s);
    pcVector_t v;
    v = '0;
    if (a2) begin
      v[VecDataAbort2] = 1'b1;
    end else if (!a) begin
      if (p) begin
        v[VecPrefetch] = 1'b1;
      end else if (u) begin
        v[VecUndef] = 1'b1;
      end else if (s) begin
        v[VecSwi] = 1'b1;
      end
    end
    return v;
  endfunction

  task automatic buildTrace();
    traceLen = 0;
    // Quiet after reset
    addRow(8'b0000_0000, 4'b0000, 7'b000_0000, 7'b00_000_00);
    addRow(8'b0000_0000, 4'b0000, 7'b000_0000, 7'b00_000_00);
    // Prefetch beats undef and SWI
    addRow(8'b0111_0000, 4'b1110, 7'b000_1000, 7'b10_000_00);
    addRow(8'b0011_0000, 4'b1110, 7'b000_0010, 7'b11_000_00);
    addRow(8'b0001_0000, 4'b1110, 7'b000_0100, 7'b11_000_00);
    // Stall runs two cycles past the last save
    addRow(8'b0000_0000, 4'b0000, 7'b000_0000, 7'b01_000_00);
    addRow(8'b0000_0000, 4'b0000, 7'b000_0000, 7'b01_000_00);
    // All causes at once
    // Abort wins with its vector one cycle late
    addRow(8'b1111_0000, 4'b1111, 7'b000_0000, 7'b00_000_00);
    addRow(8'b0000_0000, 4'b0000, 7'b001_0000, 7'b10_000_00);
    addRow(8'b0000_0000, 4'b0000, 7'b000_0000, 7'b01_000_00);
    addRow(8'b0000_0000, 4'b0000, 7'b000_0000, 7'b01_000_00);
    // Lone FIQ
    // Clear token passes D and reaches M three cycles after F
    addRow(8'b0000_1010, 4'b0000, 7'b000_0000, 7'b00_000_00);
    addRow(8'b0000_1010, 4'b0000, 7'b000_0000, 7'b00_100_00);
    addRow(8'b0000_1010, 4'b0000, 7'b000_0000, 7'b00_010_00);
    addRow(8'b0000_1010, 4'b0000, 7'b000_0000, 7'b00_000_00);
    addRow(8'b0000_1010, 4'b1010, 7'b100_0000, 7'b10_001_10);
    addRow(8'b0000_0000, 4'b0000, 7'b000_0000, 7'b01_000_00);
    addRow(8'b0000_0000, 4'b0000, 7'b000_0000, 7'b01_000_00);
    // FIQ served before IRQ when both are requested
    addRow(8'b0000_1111, 4'b0000, 7'b000_0000, 7'b00_000_00);
    addRow(8'b0000_1111, 4'b0000, 7'b000_0000, 7'b00_100_00);
    addRow(8'b0000_1111, 4'b0000, 7'b000_0000, 7'b00_010_00);
    addRow(8'b0000_1111, 4'b0000, 7'b000_0000, 7'b00_000_00);
    addRow(8'b0000_1111, 4'b1010, 7'b100_0000, 7'b10_001_10);
    // IRQ waits for the save stall to end
    addRow(8'b0000_0111, 4'b0000, 7'b000_0000, 7'b01_000_00);
    addRow(8'b0000_0111, 4'b0000, 7'b000_0000, 7'b01_000_00);
    addRow(8'b0000_0111, 4'b0000, 7'b000_0000, 7'b00_000_00);
    addRow(8'b0000_0111, 4'b0000, 7'b000_0000, 7'b00_100_00);
    addRow(8'b0000_0111, 4'b0000, 7'b000_0000, 7'b00_010_00);
    addRow(8'b0000_0111, 4'b0000, 7'b000_0000, 7'b00_000_00);
    addRow(8'b0000_0111, 4'b1010, 7'b010_0000, 7'b10_001_01);
    addRow(8'b0000_0000, 4'b0000, 7'b000_0000, 7'b01_000_00);
    addRow(8'b0000_0000, 4'b0000, 7'b000_0000, 7'b01_000_00);
    // Disabled requests never insert
    addRow(8'b0000_1100, 4'b0000, 7'b000_0000, 7'b00_000_00);
    addRow(8'b0000_1100, 4'b0000, 7'b000_0000, 7'b00_000_00);
    addRow(8'b0000_1001, 4'b0000, 7'b000_0000, 7'b00_000_00);
    // IRQ token killed in D by a SWI flush
    addRow(8'b0000_0101, 4'b0000, 7'b000_0000, 7'b00_000_00);
    addRow(8'b0000_0101, 4'b0000, 7'b000_0000, 7'b00_100_00);
    addRow(8'b0001_0101, 4'b1110, 7'b000_0100, 7'b10_010_00);
    addRow(8'b0000_0101, 4'b0000, 7'b000_0000, 7'b01_000_00);
    // Token inserted under stall is dropped and reinserted
    addRow(8'b0000_0101, 4'b0000, 7'b000_0000, 7'b01_100_00);
    addRow(8'b0000_0101, 4'b0000, 7'b000_0000, 7'b00_000_00);
    addRow(8'b0000_0101, 4'b0000, 7'b000_0000, 7'b00_100_00);
    addRow(8'b0000_0101, 4'b0000, 7'b000_0000, 7'b00_010_00);
    addRow(8'b0000_0101, 4'b0000, 7'b000_0000, 7'b00_000_00);
    addRow(8'b0000_0101, 4'b1010, 7'b010_0000, 7'b10_001_01);
    addRow(8'b0000_0000, 4'b0000, 7'b000_0000, 7'b01_000_00);
    addRow(8'b0000_0000, 4'b0000, 7'b000_0000, 7'b01_000_00);
    // Undef pre-empts FIQ in the token's M cycle
    addRow(8'b0000_1010, 4'b0000, 7'b000_0000, 7'b00_000_00);
    addRow(8'b0000_1010, 4'b0000, 7'b000_0000, 7'b00_100_00);
    addRow(8'b0000_1010, 4'b0000, 7'b000_0000, 7'b00_010_00);
    addRow(8'b0000_1010, 4'b0000, 7'b000_0000, 7'b00_000_00);
    addRow(8'b0010_1010, 4'b1110, 7'b000_0010, 7'b10_001_00);
    addRow(8'b0000_1010, 4'b0000, 7'b000_0000, 7'b01_100_00);
    addRow(8'b0000_1010, 4'b0000, 7'b000_0000, 7'b01_000_00);
    addRow(8'b0000_1010, 4'b0000, 7'b000_0000, 7'b00_100_00);
    addRow(8'b0000_1010, 4'b0000, 7'b000_0000, 7'b00_010_00);
    addRow(8'b0000_1010, 4'b0000, 7'b000_0000, 7'b00_000_00);
    addRow(8'b0000_1010, 4'b1010, 7'b100_0000, 7'b10_001_10);
    addRow(8'b0000_0000, 4'b0000, 7'b000_0000, 7'b01_000_00);
    addRow(8'b0000_0000, 4'b0000, 7'b000_0000, 7'b01_000_00);
    // Settle before the random phase
    addRow(8'b0000_0000, 4'b0000, 7'b000_0000, 7'b00_000_00);
    addRow(8'b0000_0000, 4'b0000, 7'b000_0000, 7'b00_000_00);
  endtask

  // Watchdog sized from the row counts
  initial begin
    #1;
    timeoutNs = (traceLen + RandRows + 20) * ClkPeriod;
    #(timeoutNs);
    $display("Timeout: run did not finish within %0d ns", timeoutNs);
    $display("** FAIL **");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rst  = 1'b1;
    seed = 32'h001e_ca7b;
    driveInputs(8'h00);
    buildTrace();
    @(posedge clk);
    // Reset vector and save strobe while rst is high
    for (i = 1; i < ResetCycles; i++) begin
      @(negedge clk);
      #(HalfPeriod - 1);
      where = $sformatf("reset cycle %0d", i);
      checkVector(PCVectorAddress, 7'b000_0001);
      checkBit("ExceptionSavePC", ExceptionSavePC, 1'b1);
    end
    for (i = 0; i < traceLen; i++) begin
      @(negedge clk);
      rst = 1'b0;
      driveInputs(trace[i].in);
      #(HalfPeriod - 1);
      where = $sformatf("trace row %0d", i);
      compareRow(trace[i].flush, trace[i].vec, trace[i].ctl);
    end
    // Random synchronous causes with interrupt requests masked
    modelDa2   = 1'b0;
    modelCount = 0;
    for (i = 0; i < RandRows; i++) begin
      r   = $random(seed);
      da  = (r[1:0] == 2'b00);
      pa  = (r[3:2] == 2'b00);
      ud  = (r[5:4] == 2'b00);
      swi = (r[7:6] == 2'b00);
      @(negedge clk);
      driveInputs({da, pa, ud, swi, r[8], r[9], 2'b00});
      expFlush = flushFor(da, pa, ud, swi);
      expVec   = vectorFor(modelDa2, da, pa, ud, swi);
      #(HalfPeriod - 1);
      where = $sformatf("random row %0d", i);
      compareRow(expFlush, expVec, {|expVec, modelCount != 0, 5'b00000});
      // Model state for the next cycle
      modelDa2 = da & ~modelDa2;
      if (|expVec) begin
        modelCount = SaveCycles;
      end else if (modelCount != 0) begin
        modelCount--;
      end
    end
    $display("** PASS **");
    $finish;
  end

endmodule
